//--- memControl_config.svh
// Build constants for the two-cache memory controller.
// Include wherever a word width, RAM size, RAM latency or cache count is needed.
// The package pulls this in for the word type.
`ifndef MEMCONTROL_CONFIG_SVH
`define MEMCONTROL_CONFIG_SVH

// data and address width
`define WORD_W 32

// RAM depth in words
`define RAM_WORDS 256

// cycles a request is held before the access cycle
`define RAM_LATENCY 2

// snoop pairing only works for two
`define NCACHE 2

`endif

//--- cpuTypesPkg.sv
// Types shared by the arbiter, the coherence controller and the RAM model.
// Refer to them by scoped name, e.g. cpuTypesPkg::word_t.
`default_nettype none
`include "memControl_config.svh"

package cpuTypesPkg;

	typedef logic [`WORD_W-1:0] word_t;

	typedef enum logic [1:0] {
		ramFree,   // no request
		ramBusy,   // counting latency
		ramAccess  // word done this cycle
	} ramState_t;

	typedef enum logic [1:0] {
		reqNone,
		reqIFetch,
		reqDRead,
		reqDWrite
	} reqKind_t;

	typedef enum logic [2:0] {
		idle,
		snoop,
		iMemRead,
		dWrite1,
		dWrite2,
		dRead1,
		dRead2
	} ccState_t;

endpackage

`default_nettype wire

//--- requestArbiter.sv
// Picks which cache and which kind of request goes to the coherence FSM next.
// Write-backs beat data reads, data reads beat fetches; ties go to the cache
// that was not served last. The grant is held until xferDone.
`timescale 1ns/10ps
`default_nettype none
`include "memControl_config.svh"

module requestArbiter (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic [`NCACHE-1:0]    iREN,
	input  logic [`NCACHE-1:0]    dREN,
	input  logic [`NCACHE-1:0]    dWEN,
	input  logic                  xferDone,
	output logic                  grantCache,
	output cpuTypesPkg::reqKind_t grantKind
);

	logic                  lastServed;
	logic                  pickCache;
	cpuTypesPkg::reqKind_t pickKind;

	// both asking: the one not served last, else whoever asks
	function automatic logic rotate(input logic [`NCACHE-1:0] reqs, input logic last);
		if (&reqs)
			return ~last;
		return reqs[1];
	endfunction

	always_comb
	begin
		pickCache = ~lastServed;
		pickKind = cpuTypesPkg::reqNone;
		if (|dWEN)
		begin
			pickKind = cpuTypesPkg::reqDWrite;
			pickCache = rotate(dWEN, lastServed);
		end
		else if (|dREN)
		begin
			pickKind = cpuTypesPkg::reqDRead;
			pickCache = rotate(dREN, lastServed);
		end
		else if (|iREN)
		begin
			pickKind = cpuTypesPkg::reqIFetch;
			pickCache = rotate(iREN, lastServed);
		end
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			grantKind <= cpuTypesPkg::reqNone;
			grantCache <= 1'b0;
			lastServed <= 1'b1; // cache 0 wins the first tie
		end
		else if (xferDone)
		begin
			grantKind <= cpuTypesPkg::reqNone;
			lastServed <= grantCache;
		end
		else if (grantKind == cpuTypesPkg::reqNone)
		begin
			grantKind <= pickKind;
			grantCache <= pickCache;
		end
	end

endmodule

`default_nettype wire

//--- coherenceControl.sv
// Snooping coherence FSM between two caches and one word-wide RAM.
// Takes the arbiter's grant, snoops the other cache on data reads and
// sequences the RAM words, lowering the requester's wait once per word.
// xferDone tells the arbiter the block is finished.
`timescale 1ns/10ps
`default_nettype none
`include "memControl_config.svh"

module coherenceControl (
	input  logic                               CLK,
	input  logic                               nRST,
	input  logic                               grantCache,
	input  cpuTypesPkg::reqKind_t              grantKind,
	input  logic [`NCACHE-1:0]                 dREN,
	input  logic [`NCACHE-1:0]                 dWEN,
	input  logic [`NCACHE-1:0]                 ccwrite,
	input  logic [`NCACHE-1:0]                 cctrans,
	input  cpuTypesPkg::word_t [`NCACHE-1:0]   iaddr,
	input  cpuTypesPkg::word_t [`NCACHE-1:0]   daddr,
	input  cpuTypesPkg::word_t [`NCACHE-1:0]   dstore,
	output logic [`NCACHE-1:0]                 iwait,
	output logic [`NCACHE-1:0]                 dwait,
	output logic [`NCACHE-1:0]                 ccwait,
	output logic [`NCACHE-1:0]                 ccinv,
	output cpuTypesPkg::word_t [`NCACHE-1:0]   iload,
	output cpuTypesPkg::word_t [`NCACHE-1:0]   dload,
	output cpuTypesPkg::word_t [`NCACHE-1:0]   ccsnoopaddr,
	output logic                               ramREN,
	output logic                               ramWEN,
	output cpuTypesPkg::word_t                 ramaddr,
	output cpuTypesPkg::word_t                 ramstore,
	input  cpuTypesPkg::word_t                 ramload,
	input  cpuTypesPkg::ramState_t             ramState,
	output logic                               xferDone
);

	cpuTypesPkg::ccState_t state, nextState;
	logic reqCache;
	logic snoopCache;
	logic ramDone;
	logic dirtyWb;

	assign reqCache = grantCache;
	assign snoopCache = ~grantCache;
	assign ramDone = (ramState == cpuTypesPkg::ramAccess);
	// snooper finished its lookup and is pushing the dirty word
	assign dirtyWb = (state == cpuTypesPkg::snoop) && dWEN[snoopCache] && !cctrans[snoopCache];
	assign xferDone = (state != cpuTypesPkg::idle) && (nextState == cpuTypesPkg::idle);

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
			state <= cpuTypesPkg::idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			cpuTypesPkg::idle:
			begin
				case (grantKind)
					cpuTypesPkg::reqDWrite: nextState = cpuTypesPkg::dWrite1;
					cpuTypesPkg::reqDRead:  nextState = cpuTypesPkg::snoop;
					cpuTypesPkg::reqIFetch: nextState = cpuTypesPkg::iMemRead;
					default:                nextState = cpuTypesPkg::idle;
				endcase
			end
			cpuTypesPkg::snoop:
			begin
				if (dirtyWb && ramDone)
					nextState = cpuTypesPkg::idle; // forwarded word ends the transfer
				else if (!cctrans[snoopCache] && !dWEN[snoopCache])
					nextState = cpuTypesPkg::dRead1; // clean, go to RAM
			end
			cpuTypesPkg::iMemRead:
			begin
				if (ramDone)
					nextState = cpuTypesPkg::idle;
			end
			cpuTypesPkg::dWrite1:
			begin
				if (ramDone)
					nextState = dWEN[reqCache] ? cpuTypesPkg::dWrite2 : cpuTypesPkg::idle;
			end
			cpuTypesPkg::dRead1:
			begin
				if (ramDone)
					nextState = dREN[reqCache] ? cpuTypesPkg::dRead2 : cpuTypesPkg::idle;
			end
			cpuTypesPkg::dWrite2, cpuTypesPkg::dRead2:
			begin
				if (ramDone)
					nextState = cpuTypesPkg::idle;
			end
			default: nextState = cpuTypesPkg::idle;
		endcase
	end

	always_comb
	begin
		iwait = '1;
		dwait = '1;
		ccwait = '0;
		ccinv = '0;
		iload = '0;
		dload = '0;
		ccsnoopaddr = '0;
		ramREN = 1'b0;
		ramWEN = 1'b0;
		ramaddr = '0;
		ramstore = '0;
		case (state)
			cpuTypesPkg::snoop:
			begin
				ccwait[snoopCache] = 1'b1;
				ccinv[snoopCache] = ccwrite[reqCache]; // requester wants to write
				ccsnoopaddr[snoopCache] = daddr[reqCache];
				ramWEN = dirtyWb;
				ramaddr = daddr[snoopCache];
				ramstore = dstore[snoopCache];
				dload[reqCache] = dstore[snoopCache]; // cache to cache
				if (dirtyWb && ramDone)
				begin
					dwait[reqCache] = 1'b0;
					dwait[snoopCache] = 1'b0;
				end
			end
			cpuTypesPkg::iMemRead:
			begin
				ramREN = 1'b1;
				ramaddr = iaddr[reqCache];
				iload[reqCache] = ramload;
				iwait[reqCache] = ~ramDone;
			end
			cpuTypesPkg::dWrite1, cpuTypesPkg::dWrite2:
			begin
				ramWEN = 1'b1;
				ramaddr = daddr[reqCache];
				ramstore = dstore[reqCache];
				dwait[reqCache] = ~ramDone;
			end
			cpuTypesPkg::dRead1, cpuTypesPkg::dRead2:
			begin
				ramREN = 1'b1;
				ramaddr = daddr[reqCache];
				dload[reqCache] = ramload;
				dwait[reqCache] = ~ramDone;
			end
			default:
			begin
				ramREN = 1'b0; // idle, everyone waits
			end
		endcase
	end

endmodule

`default_nettype wire

//--- ramModel.sv
// Word RAM with a fixed access latency.
// A request held at one address for RAM_LATENCY+1 cycles completes on the last
// one, shown as ramAccess. Addresses are byte addresses, word aligned.
`timescale 1ns/10ps
`default_nettype none
`include "memControl_config.svh"

module ramModel (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   ramREN,
	input  logic                   ramWEN,
	input  cpuTypesPkg::word_t     ramaddr,
	input  cpuTypesPkg::word_t     ramstore,
	output cpuTypesPkg::word_t     ramload,
	output cpuTypesPkg::ramState_t ramState
);

	localparam int idxW = $clog2(`RAM_WORDS);
	localparam int cntW = $clog2(`RAM_LATENCY + 2);
	localparam logic [cntW-1:0] lastCount = cntW'(`RAM_LATENCY);

	cpuTypesPkg::word_t mem [`RAM_WORDS];
	cpuTypesPkg::word_t lastAddr;
	logic [cntW-1:0] count;
	logic [cntW-1:0] curCount;
	logic [idxW-1:0] index;
	logic req;
	logic lastReq;

	assign req = ramREN | ramWEN;
	assign index = ramaddr[idxW+1:2];
	// new or moved request starts from zero
	assign curCount = (lastReq && ramaddr == lastAddr) ? count : '0;
	assign ramload = mem[index];

	always_comb
	begin
		if (!req)
			ramState = cpuTypesPkg::ramFree;
		else if (curCount == lastCount)
			ramState = cpuTypesPkg::ramAccess;
		else
			ramState = cpuTypesPkg::ramBusy;
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			count <= '0;
			lastReq <= 1'b0;
			lastAddr <= '0;
		end
		else
		begin
			lastReq <= req;
			lastAddr <= ramaddr;
			if (req && curCount != lastCount)
				count <= curCount + 1'b1;
			else
				count <= '0; // restart after each access
		end
	end

	always_ff @(posedge CLK)
	begin
		if (ramWEN && ramState == cpuTypesPkg::ramAccess)
			mem[index] <= ramstore;
	end

endmodule

`default_nettype wire

//--- memorySystem.sv
// Memory system top: arbiter, coherence FSM and RAM behind the two caches.
// Cache-side signals are two-element vectors indexed by cache number.
`timescale 1ns/10ps
`default_nettype none
`include "memControl_config.svh"

module memorySystem (
	input  logic                             CLK,
	input  logic                             nRST,
	input  logic [`NCACHE-1:0]               iREN,
	input  logic [`NCACHE-1:0]               dREN,
	input  logic [`NCACHE-1:0]               dWEN,
	input  logic [`NCACHE-1:0]               ccwrite,
	input  logic [`NCACHE-1:0]               cctrans,
	input  cpuTypesPkg::word_t [`NCACHE-1:0] iaddr,
	input  cpuTypesPkg::word_t [`NCACHE-1:0] daddr,
	input  cpuTypesPkg::word_t [`NCACHE-1:0] dstore,
	output logic [`NCACHE-1:0]               iwait,
	output logic [`NCACHE-1:0]               dwait,
	output logic [`NCACHE-1:0]               ccwait,
	output logic [`NCACHE-1:0]               ccinv,
	output cpuTypesPkg::word_t [`NCACHE-1:0] iload,
	output cpuTypesPkg::word_t [`NCACHE-1:0] dload,
	output cpuTypesPkg::word_t [`NCACHE-1:0] ccsnoopaddr
);

	logic grantCache;
	logic xferDone;
	logic ramREN;
	logic ramWEN;
	cpuTypesPkg::reqKind_t grantKind;
	cpuTypesPkg::word_t ramaddr;
	cpuTypesPkg::word_t ramstore;
	cpuTypesPkg::word_t ramload;
	cpuTypesPkg::ramState_t ramState;

	requestArbiter arbiter (.CLK, .nRST, .iREN, .dREN, .dWEN, .xferDone, .grantCache, .grantKind);

	coherenceControl control (
		.CLK, .nRST, .grantCache, .grantKind,
		.dREN, .dWEN, .ccwrite, .cctrans, .iaddr, .daddr, .dstore,
		.iwait, .dwait, .ccwait, .ccinv, .iload, .dload, .ccsnoopaddr,
		.ramREN, .ramWEN, .ramaddr, .ramstore, .ramload, .ramState, .xferDone
	);

	ramModel ram (.CLK, .nRST, .ramREN, .ramWEN, .ramaddr, .ramstore, .ramload, .ramState);

endmodule

`default_nettype wire

//--- memorySystem_tb.sv
// Testbench for the memory system. It plays both caches from memorySystem_cases.txt.
// Each line is one request, and lines flagged as joined start in the same cycle.
// A joined group must finish in file order. Build and run it through the Makefile.
`timescale 1ns/10ps
`default_nettype none
`include "memControl_config.svh"

module memorySystem_tb;

	localparam int nFields = 10; // words per case line

	logic CLK = 1'b0;
	logic nRST;
	logic [1:0] iREN, dREN, dWEN, ccwrite, cctrans;
	logic [1:0] iwait, dwait, ccwait, ccinv;
	cpuTypesPkg::word_t [1:0] iaddr, daddr, dstore, iload, dload, ccsnoopaddr;

	logic [31:0] caseWords [0:511];
	logic [31:0] kind [0:1], snpDirty [0:1], snpData [0:1], snpAddr [0:1], snpInv [0:1];
	int lineOf [0:1], got [0:1], need [0:1], caseErrs [0:1], snpPhase [0:1], snpLeft [0:1];
	logic [1:0] active, pending;
	int errors, checks, cases, finished, groupStart;
	int cycles = 0;
	int cycleLimit = 0;

	memorySystem UUT (
		.CLK, .nRST, .iREN, .dREN, .dWEN, .ccwrite, .cctrans, .iaddr, .daddr, .dstore,
		.iwait, .dwait, .ccwait, .ccinv, .iload, .dload, .ccsnoopaddr
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK)
	begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit)
		begin
			$display("timeout after %0d cycles, a transfer never finished", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	function automatic logic [31:0] field(input int line, input int col);
		return caseWords[9'(line * nFields + col)];
	endfunction

	function automatic string opName(input logic [31:0] k);
		case (k)
			1: return "fetch";
			3: return "write";
			4: return "read-own";
			default: return "read";
		endcase
	endfunction

	task automatic noteError(input logic c);
		errors++;
		caseErrs[c]++;
	endtask

	task automatic startCase(input int line);
		logic [31:0] w;
		logic c;
		w = field(line, 1);
		c = w[0];
		active[c] = 1'b1;
		pending[c] = 1'b0;
		lineOf[c] = line;
		got[c] = 0;
		caseErrs[c] = 0;
		kind[c] = field(line, 0) & 32'h7;
		case (kind[c])
			1:
			begin
				iREN[c] = 1'b1;
				iaddr[c] = field(line, 2);
				need[c] = 1;
			end
			3:
			begin
				dWEN[c] = 1'b1;
				daddr[c] = field(line, 2);
				dstore[c] = field(line, 3);
				need[c] = 2;
			end
			default:
			begin
				dREN[c] = 1'b1;
				daddr[c] = field(line, 2);
				ccwrite[c] = (kind[c] == 4);
				need[c] = (field(line, 6) != 0) ? 1 : 2; // dirty snoop ends after one word
				snpPhase[~c] = 0; // the other cache gets snooped
				snpLeft[~c] = field(line, 5);
				snpDirty[~c] = field(line, 6);
				snpData[~c] = field(line, 3);
				snpAddr[~c] = field(line, 2);
				snpInv[~c] = field(line, 9);
			end
		endcase
	endtask

	task automatic closeCase(input logic c);
		iREN[c] = 1'b0;
		dREN[c] = 1'b0;
		dWEN[c] = 1'b0;
		ccwrite[c] = 1'b0;
		active[c] = 1'b0;
		checks++;
		assert (finished == lineOf[c] - groupStart)
		else
		begin
			$display("Error at %0t: case %0d finished in place %0d, expected %0d", $time,
				lineOf[c] + 1, finished, lineOf[c] - groupStart);
			noteError(c);
		end
		if (kind[c] == 2 || kind[c] == 4)
		begin
			checks++;
			assert (snpPhase[~c] != 0)
			else
			begin
				$display("case %0d: data read finished without snooping the other cache",
					lineOf[c] + 1);
				noteError(c);
			end
		end
		finished++;
		$display("case %0d: cache %0d %s at %h, %0d errors", lineOf[c] + 1, c,
			opName(kind[c]), field(lineOf[c], 2), caseErrs[c]);
	endtask

	task automatic serveRequest(input logic c);
		cpuTypesPkg::word_t load;
		if (!active[c])
			return;
		if (pending[c])
		begin
			pending[c] = 1'b0;
			if (got[c] == need[c])
				closeCase(c);
			else
			begin
				daddr[c] = field(lineOf[c], 2) + 32'd4; // second word of the block
				dstore[c] = field(lineOf[c], 4);
			end
		end
		else if ((kind[c] == 1) ? !iwait[c] : !dwait[c])
		begin
			load = (kind[c] == 1) ? iload[c] : dload[c];
			if (kind[c] != 3)
			begin
				checks++;
				assert (load === field(lineOf[c], 7 + got[c]))
				else
				begin
					$display("Error at %0t: case %0d word %0d loaded %h, expected %h", $time,
						lineOf[c] + 1, got[c], load, field(lineOf[c], 7 + got[c]));
					noteError(c);
				end
			end
			got[c]++;
			pending[c] = 1'b1; // hold through the edge
		end
	endtask

	task automatic serveSnoop(input logic s);
		if (snpPhase[s] == 0 && ccwait[s])
		begin
			checks++;
			assert (ccinv[s] === snpInv[s][0] && ccsnoopaddr[s] === snpAddr[s])
			else
			begin
				$display("Error at %0t: snoop of cache %0d gave ccinv %b addr %h, expected %b %h",
					$time, s, ccinv[s], ccsnoopaddr[s], snpInv[s][0], snpAddr[s]);
				noteError(~s);
			end
			snpPhase[s] = 1;
		end
		if (snpPhase[s] == 1)
		begin
			cctrans[s] = (snpLeft[s] > 0);
			if (snpLeft[s] > 0)
				snpLeft[s]--;
			else if (snpDirty[s] != 0)
			begin
				dWEN[s] = 1'b1; // push the dirty word
				daddr[s] = snpAddr[s];
				dstore[s] = snpData[s];
				snpPhase[s] = 2;
			end
			else
				snpPhase[s] = 3;
		end
		else if (snpPhase[s] == 2 && !dwait[s])
			snpPhase[s] = 4;
		else if (snpPhase[s] == 4)
		begin
			dWEN[s] = 1'b0;
			snpPhase[s] = 3;
		end
	endtask

	initial
	begin
		int line;
		logic [31:0] opWord;
		nRST = 1'b0;
		iREN = '0;
		dREN = '0;
		dWEN = '0;
		ccwrite = '0;
		cctrans = '0;
		iaddr = '0;
		daddr = '0;
		dstore = '0;
		active = '0;
		pending = '0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 512; i++)
			caseWords[i] = '0;
		$readmemh("memorySystem_cases.txt", caseWords);
		cases = 0;
		while (field(cases, 0) != 0)
			cases++;
		cycleLimit = 16 + cases * (4 * (`RAM_LATENCY + 1) + 20);
		repeat (16) @(negedge CLK);
		nRST = 1'b1;
		@(negedge CLK);
		checks++;
		assert (iwait === 2'b11 && dwait === 2'b11 && ccwait === 2'b00 && ccinv === 2'b00)
		else
		begin
			$display("Error at %0t: after reset iwait %b dwait %b ccwait %b ccinv %b", $time,
				iwait, dwait, ccwait, ccinv);
			errors++;
		end
		line = 0;
		while (line < cases)
		begin
			@(negedge CLK);
			groupStart = line;
			snpPhase[0] = 3;
			snpPhase[1] = 3;
			do
			begin
				opWord = field(line, 0);
				startCase(line);
				line++;
			end
			while (opWord[3]);
			finished = 0;
			while (finished < line - groupStart)
			begin
				@(negedge CLK);
				serveSnoop(1'b0);
				serveSnoop(1'b1);
				serveRequest(1'b0);
				serveRequest(1'b1);
			end
		end
		$display("%0d cases, %0d checks, %0d errors", cases, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- memorySystem_cases.txt
// op cache addr d0 d1 snoopCycles dirty exp0 exp1 expInv (hex)
// op: 1 fetch, 2 read, 3 write, 4 read for ownership; +8 starts with the next line
3 0 100 11110000 11110004 0 0 0 0 0
2 1 100 0 0 1 0 11110000 11110004 0
1 0 104 0 0 0 0 11110004 0 0
1 1 100 0 0 0 0 11110000 0 0
3 1 200 22220000 22220004 0 0 0 0 0
2 0 200 dead0200 0 2 1 dead0200 0 0
2 1 200 0 0 0 0 dead0200 22220004 0
4 0 100 0 0 1 0 11110000 11110004 1
4 1 200 beef0200 0 3 1 beef0200 0 1
b 1 300 33330000 33330004 0 0 0 0 0
2 0 300 0 0 0 0 33330000 33330004 0
a 1 100 0 0 0 0 11110000 11110004 0
2 0 300 0 0 0 0 33330000 33330004 0
2 1 200 0 0 0 0 beef0200 22220004 0
a 0 300 0 0 0 0 33330000 33330004 0
2 1 100 0 0 0 0 11110000 11110004 0
1 1 300 0 0 0 0 33330000 0 0
0 0 0 0 0 0 0 0 0 0

//--- memorySystem.f
+incdir+.
cpuTypesPkg.sv
requestArbiter.sv
coherenceControl.sv
ramModel.sv
memorySystem.sv
memorySystem_tb.sv

//--- Makefile
# Verilator build and run of the memory system testbench
VERILATOR ?= verilator
TOP       ?= memorySystem_tb
FLIST     ?= memorySystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
